//--- src/tmu_pkg.sv
`default_nettype none

package tmu_pkg;

	localparam int ADR_W = 25;
	localparam int FRAC_BITS = 6;
	localparam int CSR_SEL_W = 4;

	// Word indices in the CSR block
	localparam logic [4:0] REG_STATUS = 5'd0;
	localparam logic [4:0] REG_TEX_FBUF = 5'd6;
	localparam logic [4:0] REG_TEX_HRES = 5'd7;
	localparam logic [4:0] REG_TEX_VRES = 5'd8;
	localparam logic [4:0] REG_TEX_HMASK = 5'd9;
	localparam logic [4:0] REG_TEX_VMASK = 5'd10;
	localparam logic [4:0] REG_DST_FBUF = 5'd11;
	localparam logic [4:0] REG_DST_HRES = 5'd12;
	localparam logic [4:0] REG_DST_VRES = 5'd13;

	// Default resolution after reset
	localparam logic [10:0] RST_HRES = 11'd640;
	localparam logic [10:0] RST_VRES = 11'd480;

	// 1 sign, 11 integer, 6 fractional bits
	typedef logic signed [17:0] fp_coord_t;
	typedef logic [16:0] fp_ucoord_t;
	typedef logic signed [11:0] pix_coord_t;
	typedef logic [10:0] pix_ucoord_t;
	typedef logic [10:0] res_t;
	typedef logic [FRAC_BITS-1:0] frac_t;
	// Address in 16-bit words
	typedef logic [ADR_W-1:0] mem_adr_t;

	typedef struct packed {
		mem_adr_t tex_fbuf;
		res_t tex_hres;
		res_t tex_vres;
		fp_coord_t tex_hmask;
		fp_coord_t tex_vmask;
		mem_adr_t dst_fbuf;
		res_t dst_hres;
		res_t dst_vres;
	} tmu_cfg_t;

	typedef struct packed {
		pix_coord_t dx;
		pix_coord_t dy;
		fp_coord_t tx;
		fp_coord_t ty;
	} tmu_point_t;

	typedef struct packed {
		pix_ucoord_t dx;
		pix_ucoord_t dy;
		fp_ucoord_t tx;
		fp_ucoord_t ty;
	} tmu_clamped_t;

	typedef struct packed {
		mem_adr_t dadr;
		mem_adr_t tadra;
		mem_adr_t tadrb;
		mem_adr_t tadrc;
		mem_adr_t tadrd;
		frac_t x_frac;
		frac_t y_frac;
	} tmu_adr_t;

endpackage

`default_nettype wire

//--- src/tmu_ctlif.sv
`timescale 1ns/1ps
`default_nettype none

module tmu_ctlif #(
	parameter logic [tmu_pkg::CSR_SEL_W-1:0] csr_addr = 4'h0
) (
	input logic sys_clk,
	input logic sys_rst,

	input logic [13:0] csr_a_i,
	input logic csr_we_i,
	input logic [31:0] csr_di_i,
	output logic [31:0] csr_do_o,

	input logic busy_i,
	output tmu_pkg::tmu_cfg_t cfg_o
);

	import tmu_pkg::*;

	logic csr_sel;
	logic [4:0] csr_idx;

	assign csr_sel = (csr_a_i[13:10] == csr_addr);
	assign csr_idx = csr_a_i[4:0];

	// Configuration registers
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			cfg_o.tex_fbuf <= '0;
			cfg_o.tex_hres <= RST_HRES;
			cfg_o.tex_vres <= RST_VRES;
			cfg_o.tex_hmask <= '1;
			cfg_o.tex_vmask <= '1;
			cfg_o.dst_fbuf <= '0;
			cfg_o.dst_hres <= RST_HRES;
			cfg_o.dst_vres <= RST_VRES;
		end else if (csr_sel && csr_we_i) begin
			case (csr_idx)
				REG_TEX_FBUF: cfg_o.tex_fbuf <= csr_di_i[ADR_W-1:0];
				REG_TEX_HRES: cfg_o.tex_hres <= csr_di_i[10:0];
				REG_TEX_VRES: cfg_o.tex_vres <= csr_di_i[10:0];
				REG_TEX_HMASK: cfg_o.tex_hmask <= csr_di_i[17:0];
				REG_TEX_VMASK: cfg_o.tex_vmask <= csr_di_i[17:0];
				REG_DST_FBUF: cfg_o.dst_fbuf <= csr_di_i[ADR_W-1:0];
				REG_DST_HRES: cfg_o.dst_hres <= csr_di_i[10:0];
				REG_DST_VRES: cfg_o.dst_vres <= csr_di_i[10:0];
				default: ;
			endcase
		end
	end

	// Readback one cycle after the address
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do_o <= '0;
		end else begin
			csr_do_o <= '0;
			if (csr_sel) begin
				case (csr_idx)
					REG_STATUS: csr_do_o <= {31'd0, busy_i};
					REG_TEX_FBUF: csr_do_o <= {{(32-ADR_W){1'b0}}, cfg_o.tex_fbuf};
					REG_TEX_HRES: csr_do_o <= {21'd0, cfg_o.tex_hres};
					REG_TEX_VRES: csr_do_o <= {21'd0, cfg_o.tex_vres};
					REG_TEX_HMASK: csr_do_o <= {14'd0, cfg_o.tex_hmask};
					REG_TEX_VMASK: csr_do_o <= {14'd0, cfg_o.tex_vmask};
					REG_DST_FBUF: csr_do_o <= {{(32-ADR_W){1'b0}}, cfg_o.dst_fbuf};
					REG_DST_HRES: csr_do_o <= {21'd0, cfg_o.dst_hres};
					REG_DST_VRES: csr_do_o <= {21'd0, cfg_o.dst_vres};
					default: csr_do_o <= '0;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- src/tmu_mask.sv
`timescale 1ns/1ps
`default_nettype none

module tmu_mask (
	input logic sys_clk,
	input logic sys_rst,

	input logic pipe_stb_i,
	output logic pipe_ack_o,
	input tmu_pkg::tmu_point_t point_i,

	output logic pipe_stb_o,
	input logic pipe_ack_i,
	output tmu_pkg::tmu_point_t point_o,

	input tmu_pkg::tmu_cfg_t cfg_i,
	output logic busy_o
);

	import tmu_pkg::*;

	logic valid;
	tmu_point_t masked;

	// Wrap masks let power-of-two textures tile
	always_comb begin
		masked = point_i;
		masked.tx = point_i.tx & cfg_i.tex_hmask;
		masked.ty = point_i.ty & cfg_i.tex_vmask;
	end

	assign pipe_ack_o = ~valid | pipe_ack_i;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			valid <= 1'b0;
		else if (pipe_ack_o)
			valid <= pipe_stb_i;
	end

	always_ff @(posedge sys_clk) begin
		if (pipe_stb_i && pipe_ack_o)
			point_o <= masked;
	end

	assign pipe_stb_o = valid;
	assign busy_o = valid;

endmodule

`default_nettype wire

//--- src/tmu_clamp.sv
`timescale 1ns/1ps
`default_nettype none

module tmu_clamp (
	input logic sys_clk,
	input logic sys_rst,

	input logic pipe_stb_i,
	output logic pipe_ack_o,
	input tmu_pkg::tmu_point_t point_i,

	output logic pipe_stb_o,
	input logic pipe_ack_i,
	output tmu_pkg::tmu_clamped_t point_o,

	input tmu_pkg::tmu_cfg_t cfg_i,
	output logic busy_o
);

	import tmu_pkg::*;

	logic valid;
	logic on_screen;
	tmu_clamped_t clamped;

	// Saturate into 0 .. (res-1)*64
	function automatic fp_ucoord_t clamp_coord(input fp_coord_t c, input res_t res);
		fp_ucoord_t lim;
		lim = {res - 11'd1, {FRAC_BITS{1'b0}}};
		if (c[17])
			return '0;
		else if (c[16:0] > lim)
			return lim;
		else
			return c[16:0];
	endfunction

	// Negative or beyond the resolution means off screen
	assign on_screen = ~point_i.dx[11] && (point_i.dx[10:0] < cfg_i.dst_hres)
		&& ~point_i.dy[11] && (point_i.dy[10:0] < cfg_i.dst_vres);

	always_comb begin
		clamped.dx = point_i.dx[10:0];
		clamped.dy = point_i.dy[10:0];
		clamped.tx = clamp_coord(point_i.tx, cfg_i.tex_hres);
		clamped.ty = clamp_coord(point_i.ty, cfg_i.tex_vres);
	end

	assign pipe_ack_o = ~valid | pipe_ack_i;

	// Off-screen points are taken from upstream but never stored
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			valid <= 1'b0;
		else if (pipe_ack_o)
			valid <= pipe_stb_i & on_screen;
	end

	always_ff @(posedge sys_clk) begin
		if (pipe_stb_i && pipe_ack_o)
			point_o <= clamped;
	end

	assign pipe_stb_o = valid;
	assign busy_o = valid;

endmodule

`default_nettype wire

//--- src/tmu_adrgen.sv
`timescale 1ns/1ps
`default_nettype none

module tmu_adrgen (
	input logic sys_clk,
	input logic sys_rst,

	input logic pipe_stb_i,
	output logic pipe_ack_o,
	input tmu_pkg::tmu_clamped_t point_i,

	output logic pipe_stb_o,
	input logic pipe_ack_i,
	output tmu_pkg::tmu_adr_t adr_o,

	input tmu_pkg::tmu_cfg_t cfg_i,
	output logic busy_o
);

	import tmu_pkg::*;

	// Intermediate after the multipliers
	typedef struct packed {
		logic [21:0] d_row;
		pix_ucoord_t dx;
		logic [21:0] t_row;
		logic [10:0] tx_int;
		frac_t x_frac;
		frac_t y_frac;
	} adr_s1_t;

	logic valid1;
	logic valid2;
	logic ack1;
	logic ack2;
	logic [10:0] ty_int;
	adr_s1_t s1_d;
	adr_s1_t s1_q;
	tmu_adr_t s2_d;

	assign ack2 = ~valid2 | pipe_ack_i;
	assign ack1 = ~valid1 | ack2;
	assign pipe_ack_o = ack1;

	// Step one forms row times resolution
	assign ty_int = point_i.ty[16:FRAC_BITS];

	always_comb begin
		s1_d.d_row = point_i.dy * cfg_i.dst_hres;
		s1_d.dx = point_i.dx;
		s1_d.t_row = ty_int * cfg_i.tex_hres;
		s1_d.tx_int = point_i.tx[16:FRAC_BITS];
		s1_d.x_frac = point_i.tx[FRAC_BITS-1:0];
		s1_d.y_frac = point_i.ty[FRAC_BITS-1:0];
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			valid1 <= 1'b0;
		else if (ack1)
			valid1 <= pipe_stb_i;
	end

	always_ff @(posedge sys_clk) begin
		if (pipe_stb_i && ack1)
			s1_q <= s1_d;
	end

	// Step two adds the bases and forms the four neighbours modulo 2^ADR_W
	always_comb begin
		s2_d.dadr = cfg_i.dst_fbuf + s1_q.d_row + s1_q.dx;
		s2_d.tadra = cfg_i.tex_fbuf + s1_q.t_row + s1_q.tx_int;
		s2_d.tadrb = s2_d.tadra + 1'b1;
		s2_d.tadrc = s2_d.tadra + cfg_i.tex_hres;
		s2_d.tadrd = s2_d.tadrc + 1'b1;
		s2_d.x_frac = s1_q.x_frac;
		s2_d.y_frac = s1_q.y_frac;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			valid2 <= 1'b0;
		else if (ack2)
			valid2 <= valid1;
	end

	always_ff @(posedge sys_clk) begin
		if (valid1 && ack2)
			adr_o <= s2_d;
	end

	assign pipe_stb_o = valid2;
	assign busy_o = valid1 | valid2;

endmodule

`default_nettype wire

//--- src/tmu_pointpipe.sv
`timescale 1ns/1ps
`default_nettype none

module tmu_pointpipe #(
	parameter logic [tmu_pkg::CSR_SEL_W-1:0] csr_addr = 4'h0
) (
	input logic sys_clk,
	input logic sys_rst,

	input logic [13:0] csr_a_i,
	input logic csr_we_i,
	input logic [31:0] csr_di_i,
	output logic [31:0] csr_do_o,

	input logic pipe_stb_i,
	output logic pipe_ack_o,
	input tmu_pkg::tmu_point_t point_i,

	output logic pipe_stb_o,
	input logic pipe_ack_i,
	output tmu_pkg::tmu_adr_t adr_o
);

	import tmu_pkg::*;

	tmu_cfg_t cfg;
	logic busy;

	logic mask_busy;
	logic mask_stb;
	logic mask_ack;
	tmu_point_t mask_point;

	logic clamp_busy;
	logic clamp_stb;
	logic clamp_ack;
	tmu_clamped_t clamp_point;

	logic adrgen_busy;

	tmu_ctlif #(
		.csr_addr(csr_addr)
	) u_ctlif (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr_a_i(csr_a_i),
		.csr_we_i(csr_we_i),
		.csr_di_i(csr_di_i),
		.csr_do_o(csr_do_o),
		.busy_i(busy),
		.cfg_o(cfg)
	);

	// Wrap masks
	tmu_mask u_mask (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.pipe_stb_i(pipe_stb_i),
		.pipe_ack_o(pipe_ack_o),
		.point_i(point_i),
		.pipe_stb_o(mask_stb),
		.pipe_ack_i(mask_ack),
		.point_o(mask_point),
		.cfg_i(cfg),
		.busy_o(mask_busy)
	);

	// Screen culling and texture clamp
	tmu_clamp u_clamp (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.pipe_stb_i(mask_stb),
		.pipe_ack_o(mask_ack),
		.point_i(mask_point),
		.pipe_stb_o(clamp_stb),
		.pipe_ack_i(clamp_ack),
		.point_o(clamp_point),
		.cfg_i(cfg),
		.busy_o(clamp_busy)
	);

	tmu_adrgen u_adrgen (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.pipe_stb_i(clamp_stb),
		.pipe_ack_o(clamp_ack),
		.point_i(clamp_point),
		.pipe_stb_o(pipe_stb_o),
		.pipe_ack_i(pipe_ack_i),
		.adr_o(adr_o),
		.cfg_i(cfg),
		.busy_o(adrgen_busy)
	);

	assign busy = mask_busy | clamp_busy | adrgen_busy;

endmodule

`default_nettype wire

//--- testbench/tmu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tmu_checker (
	input logic sys_clk,
	input logic sys_rst,
	input logic pipe_stb_i,
	input logic pipe_ack_i,
	input tmu_pkg::tmu_adr_t adr_i,
	input logic [31:0] csr_do_i,
	input int cycle_i
);

	import tmu_pkg::*;

	// Accept edge to output edge with an idle output port
	localparam int LATENCY = 4;

	typedef struct packed {
		logic [31:0] idx;
		logic keep;
		logic chk_lat;
		logic [31:0] cyc;
		tmu_adr_t adr;
	} exp_t;

	exp_t exp_q[$];
	int kept_pending = 0;
	int pass_count = 0;
	int fail_count = 0;

	task push_expected(input int idx, input logic keep, input logic chk_lat, input int cyc,
			input tmu_adr_t adr);
		exp_t rec;
		rec.idx = idx;
		rec.keep = keep;
		rec.chk_lat = chk_lat;
		rec.cyc = cyc;
		rec.adr = adr;
		exp_q.push_back(rec);
		if (keep)
			kept_pending++;
	endtask

	task note_failure(input string msg);
		$display("%0t: %s", $time, msg);
		fail_count++;
	endtask

	task compare_field(input string name, input logic [31:0] got, input logic [31:0] want,
			inout logic ok);
		if (got !== want) begin
			$display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, want);
			ok = 1'b0;
		end
	endtask

	// Readback value registered one cycle after the address
	task check_csr(input string name, input logic [31:0] want);
		logic ok;
		ok = 1'b1;
		compare_field(name, csr_do_i, want, ok);
		if (ok) begin
			$display("csr %s: ok", name);
			pass_count++;
		end else begin
			$display("csr %s: failed", name);
			fail_count++;
		end
	endtask

	// Dropped points at the head have been passed by every earlier output
	task retire_dropped();
		exp_t rec;
		while (exp_q.size() > 0 && !exp_q[0].keep) begin
			rec = exp_q.pop_front();
			$display("entry %0d: dropped as expected", rec.idx);
			pass_count++;
		end
	endtask

	task check_output();
		exp_t rec;
		logic ok;
		retire_dropped();
		if (exp_q.size() == 0) begin
			note_failure("an output appeared while no point was expected");
		end else begin
			rec = exp_q.pop_front();
			kept_pending--;
			ok = 1'b1;
			compare_field("dadr", adr_i.dadr, rec.adr.dadr, ok);
			compare_field("tadra", adr_i.tadra, rec.adr.tadra, ok);
			compare_field("tadrb", adr_i.tadrb, rec.adr.tadrb, ok);
			compare_field("tadrc", adr_i.tadrc, rec.adr.tadrc, ok);
			compare_field("tadrd", adr_i.tadrd, rec.adr.tadrd, ok);
			compare_field("x_frac", adr_i.x_frac, rec.adr.x_frac, ok);
			compare_field("y_frac", adr_i.y_frac, rec.adr.y_frac, ok);
			if (rec.chk_lat)
				compare_field("latency", cycle_i - rec.cyc, LATENCY, ok);
			if (ok) begin
				$display("entry %0d: ok", rec.idx);
				pass_count++;
			end else begin
				$display("entry %0d: failed", rec.idx);
				fail_count++;
			end
		end
	endtask

	always @(posedge sys_clk) begin
		if (!sys_rst && pipe_stb_i && pipe_ack_i)
			check_output();
	end

	task final_check();
		exp_t rec;
		retire_dropped();
		while (exp_q.size() > 0) begin
			rec = exp_q.pop_front();
			$display("entry %0d: expected output never appeared", rec.idx);
			fail_count++;
		end
		kept_pending = 0;
		$display("tests: %0d passed, %0d failed", pass_count, fail_count);
	endtask

endmodule

`default_nettype wire

//--- testbench/tb_tmu_pointpipe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tmu_pointpipe;

	import tmu_pkg::*;

	localparam int TABLE_LEN = 20;
	localparam int TIMEOUT_CYC = TABLE_LEN * 8 + 200;
	localparam logic [3:0] SEL = 4'h2;
	localparam int TEX_FBUF = 'h1000;
	localparam int TEX_HRES = 256;
	localparam int TEX_VRES = 128;
	localparam int DST_FBUF = 'h40000;
	localparam int DST_HRES = 320;
	localparam int DST_VRES = 200;
	localparam logic [17:0] HM = 18'h3FFFF;
	localparam logic [17:0] WM = 18'h03FFF;

	typedef struct packed {
		tmu_point_t pt;
		logic [17:0] hmask;
		logic bp;
		logic keep;
		tmu_adr_t adr;
	} entry_t;

	logic sys_clk = 1'b0;
	logic sys_rst;
	logic [13:0] csr_a_i;
	logic csr_we_i;
	logic [31:0] csr_di_i;
	logic [31:0] csr_do_o;
	logic pipe_stb_i;
	logic pipe_ack_o;
	tmu_point_t point_i;
	logic pipe_stb_o;
	logic pipe_ack_i;
	tmu_adr_t adr_o;

	int cycle = 0;
	// 0 always ready, 1 random, 2 held off
	logic [1:0] bp_mode;
	logic ack_next;
	logic [7:0] ack_bits;
	logic [7:0] gap_bits;
	logic [31:0] lfsr = 32'hc6e6_e468;

	entry_t tbl [TABLE_LEN];
	int fill_idx = 0;
	logic [4:0] reg_idx [8];
	logic [31:0] reg_val [8];
	string reg_name [8];

	tmu_pointpipe #(
		.csr_addr(SEL)
	) u_dut (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr_a_i(csr_a_i),
		.csr_we_i(csr_we_i),
		.csr_di_i(csr_di_i),
		.csr_do_o(csr_do_o),
		.pipe_stb_i(pipe_stb_i),
		.pipe_ack_o(pipe_ack_o),
		.point_i(point_i),
		.pipe_stb_o(pipe_stb_o),
		.pipe_ack_i(pipe_ack_i),
		.adr_o(adr_o)
	);

	tmu_checker u_chk (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.pipe_stb_i(pipe_stb_o),
		.pipe_ack_i(pipe_ack_i),
		.adr_i(adr_o),
		.csr_do_i(csr_do_o),
		.cycle_i(cycle)
	);

	always #10 sys_clk = ~sys_clk;

	always @(posedge sys_clk)
		cycle <= cycle + 1;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		else
			return s >> 1;
	endfunction

	task take_bits(input int n, output logic [7:0] r);
		r = '0;
		for (int k = 0; k < n; k++) begin
			r = {r[6:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// Output ready drawn on the edge and driven just after it
	always @(posedge sys_clk) begin
		if (bp_mode == 2'd1) begin
			take_bits(2, ack_bits);
			ack_next = (ack_bits != 0);
		end else begin
			ack_next = (bp_mode == 2'd0);
		end
		#1;
		pipe_ack_i = ack_next;
	end

	function automatic logic on_screen(input int dx, input int dy);
		return dx >= 0 && dx < DST_HRES && dy >= 0 && dy < DST_VRES;
	endfunction

	function automatic int apply_mask(input int c, input logic [17:0] mask);
		logic signed [17:0] m;
		m = c[17:0] & mask;
		return m;
	endfunction

	// Saturate into the texture up to the last texel column or row
	function automatic int clamp_tex(input int c, input int res);
		int lim;
		lim = (res - 1) * 64;
		if (c < 0)
			return 0;
		if (c > lim)
			return lim;
		return c;
	endfunction

	function automatic tmu_adr_t expected_adr(input int dx, input int dy, input int tx,
			input int ty, input logic [17:0] hmask);
		int ctx;
		int cty;
		tmu_adr_t a;
		ctx = clamp_tex(apply_mask(tx, hmask), TEX_HRES);
		cty = clamp_tex(apply_mask(ty, HM), TEX_VRES);
		a.dadr = DST_FBUF + dy * DST_HRES + dx;
		a.tadra = TEX_FBUF + (cty / 64) * TEX_HRES + ctx / 64;
		a.tadrb = a.tadra + 1;
		a.tadrc = a.tadra + TEX_HRES;
		a.tadrd = a.tadrc + 1;
		a.x_frac = ctx % 64;
		a.y_frac = cty % 64;
		return a;
	endfunction

	task add_entry(input int dx, input int dy, input int tx, input int ty,
			input logic [17:0] hmask, input logic bp);
		entry_t e;
		e.pt.dx = dx[11:0];
		e.pt.dy = dy[11:0];
		e.pt.tx = tx[17:0];
		e.pt.ty = ty[17:0];
		e.hmask = hmask;
		e.bp = bp;
		e.keep = on_screen(dx, dy);
		e.adr = expected_adr(dx, dy, tx, ty, hmask);
		tbl[fill_idx] = e;
		fill_idx++;
	endtask

	task build_table();
		// Back to back with no back-pressure
		add_entry(10, 20, 5 * 64 + 13, 7 * 64 + 40, HM, 0);
		add_entry(0, 0, 0, 0, HM, 0);
		add_entry(319, 199, 255 * 64 + 63, 127 * 64 + 63, HM, 0);
		add_entry(-1, 5, 100, 100, HM, 0);
		add_entry(320, 5, 100, 100, HM, 0);
		add_entry(5, 200, 100, 100, HM, 0);
		add_entry(5, -3, 100, 100, HM, 0);
		add_entry(100, 50, -200, -1, HM, 0);
		add_entry(200, 150, 2000 * 64, 30000, HM, 0);
		add_entry(1, 1, 65, 130, HM, 0);
		// Random back-pressure and gaps
		add_entry(50, 60, 1000, 2000, HM, 1);
		add_entry(400, 10, 64, 64, HM, 1);
		add_entry(318, 198, 16000, 8000, HM, 1);
		add_entry(7, 9, -5000, 3000, HM, 1);
		add_entry(12, -20, 0, 0, HM, 1);
		add_entry(160, 100, 12345, 4321, HM, 1);
		// Narrow horizontal wrap mask
		add_entry(30, 40, 20000, 500, WM, 1);
		add_entry(31, 41, -5000, -600, WM, 1);
		add_entry(-5, 0, 20000, 0, WM, 1);
		add_entry(300, 190, 131071, 8127, WM, 1);
		reg_idx = '{REG_TEX_FBUF, REG_TEX_HRES, REG_TEX_VRES, REG_TEX_HMASK,
			REG_TEX_VMASK, REG_DST_FBUF, REG_DST_HRES, REG_DST_VRES};
		reg_val = '{TEX_FBUF, TEX_HRES, TEX_VRES, {14'd0, HM}, {14'd0, HM},
			DST_FBUF, DST_HRES, DST_VRES};
		reg_name = '{"tex_fbuf", "tex_hres", "tex_vres", "tex_hmask", "tex_vmask",
			"dst_fbuf", "dst_hres", "dst_vres"};
	endtask

	task write_csr(input logic [4:0] idx, input logic [31:0] data);
		csr_a_i = {SEL, 5'd0, idx};
		csr_di_i = data;
		csr_we_i = 1'b1;
		@(posedge sys_clk);
		#1;
		csr_we_i = 1'b0;
	endtask

	task read_csr(input logic [3:0] sel, input logic [4:0] idx, input logic [31:0] want,
			input string name);
		csr_a_i = {sel, 5'd0, idx};
		csr_we_i = 1'b0;
		@(posedge sys_clk);
		@(posedge sys_clk);
		u_chk.check_csr(name, want);
		#1;
	endtask

	// Accept edge as the cycle count before that edge
	task send_point(input tmu_point_t p, output int acc_cyc, output int waits);
		pipe_stb_i = 1'b1;
		point_i = p;
		@(posedge sys_clk);
		waits = 1;
		while (!pipe_ack_o) begin
			@(posedge sys_clk);
			waits++;
		end
		acc_cyc = cycle;
		#1;
		pipe_stb_i = 1'b0;
	endtask

	task drain_pipe();
		if (bp_mode == 2'd1 && u_chk.kept_pending > 0) begin
			bp_mode = 2'd2;
			read_csr(SEL, REG_STATUS, 1, "status busy while held");
			bp_mode = 2'd1;
		end
		while (u_chk.kept_pending != 0) begin
			@(posedge sys_clk);
			#1;
		end
		repeat (3) @(posedge sys_clk);
		#1;
		read_csr(SEL, REG_STATUS, 0, "status idle after drain");
		u_chk.retire_dropped();
	endtask

	initial begin
		int acc_cyc;
		int waits;
		logic [17:0] cur_mask;
		logic cur_bp;
		sys_rst = 1'b1;
		csr_a_i = '0;
		csr_we_i = 1'b0;
		csr_di_i = '0;
		pipe_stb_i = 1'b0;
		point_i = '0;
		pipe_ack_i = 1'b1;
		bp_mode = 2'd0;
		build_table();
		repeat (3) @(posedge sys_clk);
		#1;
		sys_rst = 1'b0;
		read_csr(SEL, REG_STATUS, 0, "status idle after reset");
		read_csr(SEL, REG_TEX_HRES, 640, "tex_hres reset value");
		for (int i = 0; i < 8; i++)
			write_csr(reg_idx[i], reg_val[i]);
		for (int i = 0; i < 8; i++)
			read_csr(SEL, reg_idx[i], reg_val[i], reg_name[i]);
		read_csr(4'h3, REG_TEX_HRES, 0, "unselected block");
		cur_mask = HM;
		cur_bp = 1'b0;
		for (int i = 0; i < TABLE_LEN; i++) begin
			if (tbl[i].hmask != cur_mask || tbl[i].bp != cur_bp) begin
				drain_pipe();
				if (tbl[i].hmask != cur_mask) begin
					write_csr(REG_TEX_HMASK, {14'd0, tbl[i].hmask});
					read_csr(SEL, REG_TEX_HMASK, {14'd0, tbl[i].hmask}, "tex_hmask wrap");
					cur_mask = tbl[i].hmask;
				end
				cur_bp = tbl[i].bp;
				bp_mode = cur_bp ? 2'd1 : 2'd0;
			end
			if (cur_bp) begin
				take_bits(2, gap_bits);
				if (gap_bits == 0) begin
					@(posedge sys_clk);
					#1;
				end
			end
			send_point(tbl[i].pt, acc_cyc, waits);
			// Back to back input must be taken every cycle
			if (!cur_bp && waits != 1)
				u_chk.note_failure($sformatf("entry %0d waited %0d cycles for input ready",
					i, waits));
			u_chk.push_expected(i, tbl[i].keep, !cur_bp, acc_cyc, tbl[i].adr);
		end
		drain_pipe();
		u_chk.final_check();
		if (u_chk.fail_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		wait (cycle >= TIMEOUT_CYC);
		$display("timeout: the run did not complete within %0d cycles", TIMEOUT_CYC);
		u_chk.final_check();
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
src/tmu_pkg.sv
src/tmu_ctlif.sv
src/tmu_mask.sv
src/tmu_clamp.sv
src/tmu_adrgen.sv
src/tmu_pointpipe.sv
testbench/tmu_checker.sv
testbench/tb_tmu_pointpipe.sv
